// File: include/soc_defines.svh
// --------------------
// badge soc i/o
// region codes, misc register map, reload and reset constants
// --------------------
`ifndef SOC_DEFINES_SVH
`define SOC_DEFINES_SVH

// address bits 31:28
`define SOC_REGION_MISC 4'h2
`define SOC_REGION_RAM 4'h4

// misc register indices, address bits 6:2
`define MISC_REG_LED 5'd0
`define MISC_REG_BTN 5'd1
`define MISC_REG_SOC_VER 5'd2
`define MISC_REG_FLASH_SEL 5'd13
`define MISC_REG_GENIO_IN 5'd17
`define MISC_REG_GENIO_OUT 5'd18
`define MISC_REG_GENIO_OE 5'd19
`define MISC_REG_GENIO_W2S 5'd20
`define MISC_REG_GENIO_W2C 5'd21
`define MISC_REG_GPEXT_IN 5'd22
`define MISC_REG_GPEXT_OUT 5'd23
`define MISC_REG_GPEXT_OE 5'd24
`define MISC_REG_GPEXT_W2S 5'd25
`define MISC_REG_GPEXT_W2C 5'd26

`define SOC_VERSION 32'h0000
`define BUS_ERROR_DATA 32'hDEADBEEF

// upper 24 bits of a flash-select write that arm the reconfiguration
`define RELOAD_MAGIC 24'hD0F1A5
`define FSEL_DELAY_START 3'd7

`define RAM_WORDS 64

// irda transceiver starts out shut down
`define IRDA_SD_RESET 1'b1

`endif

// File: source/soc_pkg.sv
// --------------------
// soc_pkg
// bus and register types shared by the badge soc i/o blocks
// --------------------
`default_nettype none

package soc_pkg;

	// bus words and strobes
	typedef logic [31:0] bus_word_t;
	typedef logic [3:0] bus_strb_t;

	// misc register index, address bits 6:2
	typedef logic [4:0] reg_index_t;

	// pin groups
	typedef logic [29:0] genio_t;
	typedef logic [5:0] sao_t;
	typedef logic [7:0] pmod_t;

	// scratch ram word index, address bits 7:2
	typedef logic [5:0] ram_index_t;

	// decoder tracking of the ram wait state
	typedef enum logic [1:0] {
		dec_idle,
		dec_wait_ram,
		dec_done
	} dec_state_t;

endpackage

`default_nettype wire

// File: source/periph_bus_if.sv
// --------------------
// periph_bus_if
// request and response of one decoded bus target
// --------------------
`default_nettype none

interface periph_bus_if
	import soc_pkg::*;
();

	logic sel;
	bus_word_t addr;
	bus_word_t wdata;
	bus_strb_t wstrb;
	bus_word_t rdata;
	logic ready;

	modport decoder (
		output sel, addr, wdata, wstrb,
		input rdata, ready
	);

	modport target (
		input sel, addr, wdata, wstrb,
		output rdata, ready
	);

endinterface

`default_nettype wire

// File: source/bus_decoder.sv
// --------------------
// bus_decoder
// splits the master port by address region into misc, ram and bus error,
// and muxes read data and ready back
// --------------------
`default_nettype none

`include "soc_defines.svh"

module bus_decoder
	import soc_pkg::*;
(
	input wire logic i_clk48m,
	input wire logic i_rst,
	input wire logic i_mem_valid,
	input wire bus_word_t i_mem_addr,
	input wire bus_word_t i_mem_wdata,
	input wire bus_strb_t i_mem_wstrb,
	output bus_word_t o_mem_rdata,
	output logic o_mem_ready,
	output logic o_bus_error,
	periph_bus_if.decoder misc,
	periph_bus_if.decoder ram
);

	dec_state_t state;
	logic hit_misc;
	logic hit_ram;

	assign hit_misc = (i_mem_addr[31:28] == `SOC_REGION_MISC);
	assign hit_ram = (i_mem_addr[31:28] == `SOC_REGION_RAM);

	// request fan-out
	assign misc.sel = i_mem_valid && hit_misc;
	assign misc.addr = i_mem_addr;
	assign misc.wdata = i_mem_wdata;
	assign misc.wstrb = i_mem_wstrb;

	// ram select drops once its access is done, until valid goes low
	assign ram.sel = i_mem_valid && hit_ram && (state != dec_done);
	assign ram.addr = i_mem_addr;
	assign ram.wdata = i_mem_wdata;
	assign ram.wstrb = i_mem_wstrb;

	// --------------------
	// response mux
	// --------------------
	always_comb begin
		o_mem_rdata = `BUS_ERROR_DATA;
		o_mem_ready = 1'b0;
		o_bus_error = 1'b0;
		if (hit_misc) begin
			o_mem_rdata = misc.rdata;
			o_mem_ready = misc.ready;
		end else if (hit_ram) begin
			o_mem_rdata = ram.rdata;
			o_mem_ready = ram.ready && (state == dec_wait_ram);
		end else begin
			// unmapped, answer at once with the error word
			o_mem_ready = i_mem_valid;
			o_bus_error = i_mem_valid;
		end
	end

	// --------------------
	// ram wait state tracking
	// --------------------
	always_ff @(posedge i_clk48m) begin
		if (i_rst) begin
			state <= dec_idle;
		end else begin
			case (state)
				dec_idle: begin
					if (i_mem_valid && hit_ram) begin
						state <= dec_wait_ram;
					end
				end
				dec_wait_ram: begin
					if (ram.ready) begin
						state <= dec_done;
					end
				end
				dec_done: begin
					// master lowers valid between transactions
					if (!i_mem_valid) begin
						state <= dec_idle;
					end
				end
				default: state <= dec_idle;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: source/misc_regs.sv
// --------------------
// misc_regs
// led, button, version and i/o registers of region 2
// general and extension i/o support write-to-set and write-to-clear
// --------------------
`default_nettype none

`include "soc_defines.svh"

module misc_regs
	import soc_pkg::*;
(
	periph_bus_if.target bus,
	input wire logic i_clk48m,
	input wire logic i_rst,
	input wire logic [7:0] i_btn,
	input wire genio_t i_genio_in,
	input wire sao_t i_sao1_in,
	input wire sao_t i_sao2_in,
	input wire pmod_t i_pmod_in,
	input wire logic i_usb_vdet,
	output logic [8:0] o_led,
	output logic o_trace_en,
	output genio_t o_genio_out,
	output genio_t o_genio_oe,
	output sao_t o_sao1_out,
	output sao_t o_sao1_oe,
	output sao_t o_sao2_out,
	output sao_t o_sao2_oe,
	output pmod_t o_pmod_out,
	output pmod_t o_pmod_oe,
	output logic o_irda_sd,
	output logic o_fsel_strobe,
	output logic o_fsel_value,
	output logic o_reload_req
);

	reg_index_t idx;
	logic wr_en;
	logic [15:0] led_q;

	assign idx = bus.addr[6:2];
	assign wr_en = bus.sel && bus.wstrb[0];

	// zero wait states
	assign bus.ready = bus.sel;
	assign o_led = led_q[8:0];

	// flash select goes straight to the reload sequencer
	assign o_fsel_strobe = wr_en && (idx == `MISC_REG_FLASH_SEL);
	assign o_fsel_value = bus.wdata[0];
	assign o_reload_req = o_fsel_strobe && (bus.wdata[31:8] == `RELOAD_MAGIC);

	// --------------------
	// read path
	// --------------------
	always_comb begin
		case (idx)
			`MISC_REG_LED: bus.rdata = {16'h0, led_q};
			`MISC_REG_BTN: bus.rdata = {24'h0, ~i_btn};
			`MISC_REG_SOC_VER: bus.rdata = `SOC_VERSION;
			`MISC_REG_GENIO_IN: bus.rdata = {2'h0, i_genio_in};
			`MISC_REG_GENIO_OUT: bus.rdata = {2'h0, o_genio_out};
			`MISC_REG_GENIO_OE: bus.rdata = {2'h0, o_genio_oe};
			`MISC_REG_GPEXT_IN: begin
				bus.rdata = {i_usb_vdet, 7'h0, i_pmod_in, 2'h0, i_sao2_in, 2'h0, i_sao1_in};
			end
			`MISC_REG_GPEXT_OUT: begin
				bus.rdata = {1'b0, o_irda_sd, 6'h0, o_pmod_out, 2'h0, o_sao2_out,
					2'h0, o_sao1_out};
			end
			`MISC_REG_GPEXT_OE: begin
				bus.rdata = {8'h0, o_pmod_oe, 2'h0, o_sao2_oe, 2'h0, o_sao1_oe};
			end
			// set/clear ports, flash select and dropped registers
			default: bus.rdata = '0;
		endcase
	end

	// --------------------
	// write path
	// --------------------
	always_ff @(posedge i_clk48m) begin
		if (i_rst) begin
			led_q <= '0;
			o_trace_en <= 1'b0;
			o_genio_out <= '0;
			o_genio_oe <= '0;
			o_sao1_out <= '0;
			o_sao1_oe <= '0;
			o_sao2_out <= '0;
			o_sao2_oe <= '0;
			o_pmod_out <= '0;
			o_pmod_oe <= '0;
			o_irda_sd <= `IRDA_SD_RESET;
		end else if (wr_en) begin
			case (idx)
				`MISC_REG_LED: led_q <= bus.wdata[15:0];
				`MISC_REG_SOC_VER: o_trace_en <= bus.wdata[0];
				`MISC_REG_GENIO_OUT: o_genio_out <= bus.wdata[29:0];
				`MISC_REG_GENIO_OE: o_genio_oe <= bus.wdata[29:0];
				`MISC_REG_GENIO_W2S: o_genio_out <= o_genio_out | bus.wdata[29:0];
				`MISC_REG_GENIO_W2C: o_genio_out <= o_genio_out & ~bus.wdata[29:0];
				`MISC_REG_GPEXT_OUT: begin
					o_irda_sd <= bus.wdata[30];
					o_pmod_out <= bus.wdata[23:16];
					o_sao2_out <= bus.wdata[13:8];
					o_sao1_out <= bus.wdata[5:0];
				end
				`MISC_REG_GPEXT_OE: begin
					o_pmod_oe <= bus.wdata[23:16];
					o_sao2_oe <= bus.wdata[13:8];
					o_sao1_oe <= bus.wdata[5:0];
				end
				// set and clear act on the output fields only
				`MISC_REG_GPEXT_W2S: begin
					o_irda_sd <= o_irda_sd | bus.wdata[30];
					o_pmod_out <= o_pmod_out | bus.wdata[23:16];
					o_sao2_out <= o_sao2_out | bus.wdata[13:8];
					o_sao1_out <= o_sao1_out | bus.wdata[5:0];
				end
				`MISC_REG_GPEXT_W2C: begin
					o_irda_sd <= o_irda_sd & ~bus.wdata[30];
					o_pmod_out <= o_pmod_out & ~bus.wdata[23:16];
					o_sao2_out <= o_sao2_out & ~bus.wdata[13:8];
					o_sao1_out <= o_sao1_out & ~bus.wdata[5:0];
				end
				default: begin
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// File: source/reload_sequencer.sv
// --------------------
// reload_sequencer
// clocks the flash-select flip-flop, then optionally pulls programn
// --------------------
`default_nettype none

`include "soc_defines.svh"

module reload_sequencer (
	input wire logic i_clk48m,
	input wire logic i_rst,
	input wire logic i_fsel_strobe,
	input wire logic i_fsel_value,
	input wire logic i_reload_req,
	output logic o_fsel_d,
	output logic o_fsel_c,
	output logic o_programn
);

	logic strobe_q;
	logic reload_queued;
	logic reload_q;
	logic [2:0] fsel_delay;

	// select d is set well before the clock window opens
	assign o_fsel_c = (fsel_delay == 3'd5) || (fsel_delay == 3'd4) || (fsel_delay == 3'd3);
	assign o_programn = ~reload_q;

	always_ff @(posedge i_clk48m) begin
		if (i_rst) begin
			strobe_q <= 1'b0;
			reload_queued <= 1'b0;
			reload_q <= 1'b0;
			fsel_delay <= '0;
			o_fsel_d <= 1'b0;
		end else begin
			strobe_q <= i_fsel_strobe;
			if (i_fsel_strobe) begin
				o_fsel_d <= i_fsel_value;
				if (i_reload_req) begin
					reload_queued <= 1'b1;
				end
			end
			if (strobe_q) begin
				fsel_delay <= `FSEL_DELAY_START;
			end else if (fsel_delay != 3'd0) begin
				fsel_delay <= fsel_delay - 3'd1;
				// reconfigure only after the select clock window is over
				if (fsel_delay == 3'd1 && reload_queued) begin
					reload_q <= 1'b1;
				end
			end
		end
	end

endmodule

`default_nettype wire

// File: source/scratch_ram.sv
// --------------------
// scratch_ram
// small word ram with byte strobes, one wait state
// --------------------
`default_nettype none

`include "soc_defines.svh"

module scratch_ram
	import soc_pkg::*;
(
	periph_bus_if.target bus,
	input wire logic i_clk48m,
	input wire logic i_rst
);

	bus_word_t mem [`RAM_WORDS];
	bus_word_t rdata_q;
	ram_index_t idx;
	logic ready_q;
	logic access;

	assign idx = bus.addr[7:2];
	// first cycle of select only
	assign access = bus.sel && !ready_q;

	assign bus.rdata = rdata_q;
	assign bus.ready = ready_q;

	always_ff @(posedge i_clk48m) begin
		if (i_rst) begin
			ready_q <= 1'b0;
		end else begin
			ready_q <= access;
		end
	end

	// data path
	always_ff @(posedge i_clk48m) begin
		if (access) begin
			rdata_q <= mem[idx];
			for (int b = 0; b < 4; b++) begin
				if (bus.wstrb[b]) begin
					mem[idx][8*b +: 8] <= bus.wdata[8*b +: 8];
				end
			end
		end
	end

endmodule

`default_nettype wire

// File: source/soc_io_top.sv
// --------------------
// soc_io_top
// address decoding and on-board control registers of the badge soc
// --------------------
`default_nettype none

module soc_io_top
	import soc_pkg::*;
(
	input wire logic i_clk48m,
	input wire logic i_rst,

	// master port
	input wire logic i_mem_valid,
	input wire bus_word_t i_mem_addr,
	input wire bus_word_t i_mem_wdata,
	input wire bus_strb_t i_mem_wstrb,
	output bus_word_t o_mem_rdata,
	output logic o_mem_ready,
	output logic o_bus_error,

	// board pins
	input wire logic [7:0] i_btn,
	input wire genio_t i_genio_in,
	input wire sao_t i_sao1_in,
	input wire sao_t i_sao2_in,
	input wire pmod_t i_pmod_in,
	input wire logic i_usb_vdet,
	output logic [8:0] o_led,
	output logic o_trace_en,
	output genio_t o_genio_out,
	output genio_t o_genio_oe,
	output sao_t o_sao1_out,
	output sao_t o_sao1_oe,
	output sao_t o_sao2_out,
	output sao_t o_sao2_oe,
	output pmod_t o_pmod_out,
	output pmod_t o_pmod_oe,
	output logic o_irda_sd,
	output logic o_fsel_d,
	output logic o_fsel_c,
	output logic o_programn
);

	logic fsel_strobe;
	logic fsel_value;
	logic reload_req;

	periph_bus_if misc_bus ();
	periph_bus_if ram_bus ();

	bus_decoder i_bus_decoder (
		.i_clk48m(i_clk48m),
		.i_rst(i_rst),
		.i_mem_valid(i_mem_valid),
		.i_mem_addr(i_mem_addr),
		.i_mem_wdata(i_mem_wdata),
		.i_mem_wstrb(i_mem_wstrb),
		.o_mem_rdata(o_mem_rdata),
		.o_mem_ready(o_mem_ready),
		.o_bus_error(o_bus_error),
		.misc(misc_bus.decoder),
		.ram(ram_bus.decoder)
	);

	misc_regs i_misc_regs (
		.bus(misc_bus.target),
		.i_clk48m(i_clk48m),
		.i_rst(i_rst),
		.i_btn(i_btn),
		.i_genio_in(i_genio_in),
		.i_sao1_in(i_sao1_in),
		.i_sao2_in(i_sao2_in),
		.i_pmod_in(i_pmod_in),
		.i_usb_vdet(i_usb_vdet),
		.o_led(o_led),
		.o_trace_en(o_trace_en),
		.o_genio_out(o_genio_out),
		.o_genio_oe(o_genio_oe),
		.o_sao1_out(o_sao1_out),
		.o_sao1_oe(o_sao1_oe),
		.o_sao2_out(o_sao2_out),
		.o_sao2_oe(o_sao2_oe),
		.o_pmod_out(o_pmod_out),
		.o_pmod_oe(o_pmod_oe),
		.o_irda_sd(o_irda_sd),
		.o_fsel_strobe(fsel_strobe),
		.o_fsel_value(fsel_value),
		.o_reload_req(reload_req)
	);

	reload_sequencer i_reload_sequencer (
		.i_clk48m(i_clk48m),
		.i_rst(i_rst),
		.i_fsel_strobe(fsel_strobe),
		.i_fsel_value(fsel_value),
		.i_reload_req(reload_req),
		.o_fsel_d(o_fsel_d),
		.o_fsel_c(o_fsel_c),
		.o_programn(o_programn)
	);

	scratch_ram i_scratch_ram (
		.bus(ram_bus.target),
		.i_clk48m(i_clk48m),
		.i_rst(i_rst)
	);

endmodule

`default_nettype wire

// File: verif/soc_io_checker.sv
// --------------------
// soc_io_checker
// watches the master port and the pins of the badge soc i/o block,
// keeps a model of the register map and ram, counts mismatches
// --------------------
`default_nettype none

`include "soc_defines.svh"

module soc_io_checker
	import soc_pkg::*;
(
	input wire logic i_clk48m,
	input wire logic i_rst,
	input wire logic i_valid,
	input wire bus_word_t i_addr,
	input wire bus_word_t i_wdata,
	input wire bus_strb_t i_wstrb,
	input wire bus_word_t i_rdata,
	input wire logic i_ready,
	input wire logic i_bus_error,
	input wire logic [7:0] i_btn,
	input wire genio_t i_genio_in,
	input wire sao_t i_sao1_in,
	input wire sao_t i_sao2_in,
	input wire pmod_t i_pmod_in,
	input wire logic i_usb_vdet,
	input wire logic [8:0] i_led,
	input wire logic i_trace_en,
	input wire genio_t i_genio_out,
	input wire genio_t i_genio_oe,
	input wire sao_t i_sao1_out,
	input wire sao_t i_sao1_oe,
	input wire sao_t i_sao2_out,
	input wire sao_t i_sao2_oe,
	input wire pmod_t i_pmod_out,
	input wire pmod_t i_pmod_oe,
	input wire logic i_irda_sd,
	input wire logic i_fsel_d,
	input wire logic i_fsel_c,
	input wire logic i_programn
);

	// extension word fields for headers, pmod and irda shutdown
	localparam bus_word_t gpext_out_mask = 32'h40FF3F3F;
	localparam bus_word_t gpext_oe_mask = 32'h00FF3F3F;

	string test_name = "reset";
	int check_count = 0;
	int error_count = 0;

	// --------------------
	// model state
	// --------------------
	logic [15:0] led_m;
	logic trace_m;
	genio_t genio_out_m;
	genio_t genio_oe_m;
	bus_word_t gpext_out_m;
	bus_word_t gpext_oe_m;
	bus_word_t ram_m [`RAM_WORDS];
	logic fsel_d_m;
	logic reload_armed;
	logic programn_low;
	// edges since a flash-select write was accepted
	// zero while no write is pending
	int fsel_since;
	int wait_cycles;

	// expected read data of an address
	function automatic bus_word_t ref_read(input bus_word_t addr);
		bus_word_t data;
		data = '0;
		if (addr[31:28] == `SOC_REGION_RAM) begin
			data = ram_m[addr[7:2]];
		end else if (addr[31:28] != `SOC_REGION_MISC) begin
			data = `BUS_ERROR_DATA;
		end else begin
			case (addr[6:2])
				`MISC_REG_LED: data = {16'h0, led_m};
				`MISC_REG_BTN: data = {24'h0, ~i_btn};
				`MISC_REG_SOC_VER: data = `SOC_VERSION;
				`MISC_REG_GENIO_IN: data = {2'h0, i_genio_in};
				`MISC_REG_GENIO_OUT: data = {2'h0, genio_out_m};
				`MISC_REG_GENIO_OE: data = {2'h0, genio_oe_m};
				`MISC_REG_GPEXT_IN: begin
					// headers at 5:0 and 13:8, pmod at 23:16, usb detect on top
					data[5:0] = i_sao1_in;
					data[13:8] = i_sao2_in;
					data[23:16] = i_pmod_in;
					data[31] = i_usb_vdet;
				end
				`MISC_REG_GPEXT_OUT: data = gpext_out_m;
				`MISC_REG_GPEXT_OE: data = gpext_oe_m;
				default: data = '0;
			endcase
		end
		return data;
	endfunction

	task automatic apply_write(input bus_word_t addr, input bus_word_t data,
		input bus_strb_t strb);
		ram_index_t widx;
		widx = addr[7:2];
		if (addr[31:28] == `SOC_REGION_RAM) begin
			for (int b = 0; b < 4; b++) begin
				if (strb[b]) begin
					ram_m[widx][8*b +: 8] = data[8*b +: 8];
				end
			end
		end else if (addr[31:28] == `SOC_REGION_MISC && strb[0]) begin
			case (addr[6:2])
				`MISC_REG_LED: led_m = data[15:0];
				`MISC_REG_SOC_VER: trace_m = data[0];
				`MISC_REG_GENIO_OUT: genio_out_m = data[29:0];
				`MISC_REG_GENIO_OE: genio_oe_m = data[29:0];
				`MISC_REG_GENIO_W2S: genio_out_m = genio_out_m | data[29:0];
				`MISC_REG_GENIO_W2C: genio_out_m = genio_out_m & ~data[29:0];
				`MISC_REG_GPEXT_OUT: gpext_out_m = data & gpext_out_mask;
				`MISC_REG_GPEXT_OE: gpext_oe_m = data & gpext_oe_mask;
				`MISC_REG_GPEXT_W2S: gpext_out_m = gpext_out_m | (data & gpext_out_mask);
				`MISC_REG_GPEXT_W2C: gpext_out_m = gpext_out_m & ~(data & gpext_out_mask);
				`MISC_REG_FLASH_SEL: begin
					fsel_d_m = data[0];
					fsel_since = 1;
					if (data[31:8] == `RELOAD_MAGIC) begin
						reload_armed = 1'b1;
					end
				end
				default: begin
				end
			endcase
		end
	endtask

	task automatic compare(input string what, input bus_word_t expected,
		input bus_word_t actual);
		check_count++;
		if (actual !== expected) begin
			error_count++;
			$display("error %s: %s expected %h actual %h", test_name, what, expected, actual);
		end
	endtask

	task automatic check_pins();
		compare("led pins", {23'h0, led_m[8:0]}, {23'h0, i_led});
		compare("trace_en", {31'h0, trace_m}, {31'h0, i_trace_en});
		compare("genio_out pins", {2'h0, genio_out_m}, {2'h0, i_genio_out});
		compare("genio_oe pins", {2'h0, genio_oe_m}, {2'h0, i_genio_oe});
		compare("gpext out pins", gpext_out_m,
			{1'b0, i_irda_sd, 6'h0, i_pmod_out, 2'h0, i_sao2_out, 2'h0, i_sao1_out});
		compare("gpext oe pins", gpext_oe_m,
			{8'h0, i_pmod_oe, 2'h0, i_sao2_oe, 2'h0, i_sao1_oe});
		compare("fsel_d", {31'h0, fsel_d_m}, {31'h0, i_fsel_d});
		// select clock window while the counter holds 5, 4 and 3
		compare("fsel_c", {31'h0, fsel_since >= 4 && fsel_since <= 6}, {31'h0, i_fsel_c});
		compare("programn", {31'h0, !programn_low}, {31'h0, i_programn});
	endtask

	task automatic check_bus();
		logic [3:0] region;
		logic mapped;
		region = i_addr[31:28];
		mapped = (region == `SOC_REGION_MISC) || (region == `SOC_REGION_RAM);
		if (!i_valid) begin
			compare("idle ready", 32'h0, {31'h0, i_ready});
			compare("idle bus_error", 32'h0, {31'h0, i_bus_error});
			wait_cycles = 0;
		end else if (!i_ready) begin
			wait_cycles++;
		end else begin
			// one wait state for ram and none elsewhere
			compare("wait states", (region == `SOC_REGION_RAM) ? 32'd1 : 32'd0, wait_cycles);
			compare("bus_error", {31'h0, !mapped}, {31'h0, i_bus_error});
			if (i_wstrb == 4'h0 || !mapped) begin
				compare("read data", ref_read(i_addr), i_rdata);
			end
			wait_cycles = 0;
		end
	endtask

	always @(posedge i_clk48m) begin
		if (i_rst) begin
			led_m = '0;
			trace_m = 1'b0;
			genio_out_m = '0;
			genio_oe_m = '0;
			gpext_out_m = {1'b0, `IRDA_SD_RESET, 30'h0};
			gpext_oe_m = '0;
			fsel_d_m = 1'b0;
			reload_armed = 1'b0;
			programn_low = 1'b0;
			fsel_since = 0;
			wait_cycles = 0;
		end else begin
			check_pins();
			check_bus();
			// counter leaves 1 here so programn is low from the next edge
			if (reload_armed && fsel_since == 8) begin
				programn_low = 1'b1;
			end
			if (fsel_since != 0 && fsel_since < 20) begin
				fsel_since++;
			end
			if (i_valid && i_ready && i_wstrb != 4'h0) begin
				apply_write(i_addr, i_wdata, i_wstrb);
			end
		end
	end

endmodule

`default_nettype wire

// File: verif/tb_soc_io.sv
// --------------------
// tb_soc_io
// plays the bus master for the badge soc i/o block and drives its pins
// --------------------
`default_nettype none

`include "soc_defines.svh"

module tb_soc_io
	import soc_pkg::*;
();

	logic clk48m = 1'b0;
	logic rst;

	// master port
	logic mem_valid;
	bus_word_t mem_addr;
	bus_word_t mem_wdata;
	bus_strb_t mem_wstrb;
	bus_word_t mem_rdata;
	logic mem_ready;
	logic bus_error;

	// board pins
	logic [7:0] btn;
	genio_t genio_in;
	sao_t sao1_in;
	sao_t sao2_in;
	pmod_t pmod_in;
	logic usb_vdet;
	logic [8:0] led;
	logic trace_en;
	genio_t genio_out;
	genio_t genio_oe;
	sao_t sao1_out;
	sao_t sao1_oe;
	sao_t sao2_out;
	sao_t sao2_oe;
	pmod_t pmod_out;
	pmod_t pmod_oe;
	logic irda_sd;
	logic fsel_d;
	logic fsel_c;
	logic programn;

	integer seed;
	bus_word_t rnd;
	int failure_count;

	always #2 clk48m = ~clk48m;

	soc_io_top i_dut (
		.i_clk48m(clk48m),
		.i_rst(rst),
		.i_mem_valid(mem_valid),
		.i_mem_addr(mem_addr),
		.i_mem_wdata(mem_wdata),
		.i_mem_wstrb(mem_wstrb),
		.o_mem_rdata(mem_rdata),
		.o_mem_ready(mem_ready),
		.o_bus_error(bus_error),
		.i_btn(btn),
		.i_genio_in(genio_in),
		.i_sao1_in(sao1_in),
		.i_sao2_in(sao2_in),
		.i_pmod_in(pmod_in),
		.i_usb_vdet(usb_vdet),
		.o_led(led),
		.o_trace_en(trace_en),
		.o_genio_out(genio_out),
		.o_genio_oe(genio_oe),
		.o_sao1_out(sao1_out),
		.o_sao1_oe(sao1_oe),
		.o_sao2_out(sao2_out),
		.o_sao2_oe(sao2_oe),
		.o_pmod_out(pmod_out),
		.o_pmod_oe(pmod_oe),
		.o_irda_sd(irda_sd),
		.o_fsel_d(fsel_d),
		.o_fsel_c(fsel_c),
		.o_programn(programn)
	);

	soc_io_checker i_checker (
		.i_clk48m(clk48m),
		.i_rst(rst),
		.i_valid(mem_valid),
		.i_addr(mem_addr),
		.i_wdata(mem_wdata),
		.i_wstrb(mem_wstrb),
		.i_rdata(mem_rdata),
		.i_ready(mem_ready),
		.i_bus_error(bus_error),
		.i_btn(btn),
		.i_genio_in(genio_in),
		.i_sao1_in(sao1_in),
		.i_sao2_in(sao2_in),
		.i_pmod_in(pmod_in),
		.i_usb_vdet(usb_vdet),
		.i_led(led),
		.i_trace_en(trace_en),
		.i_genio_out(genio_out),
		.i_genio_oe(genio_oe),
		.i_sao1_out(sao1_out),
		.i_sao1_oe(sao1_oe),
		.i_sao2_out(sao2_out),
		.i_sao2_oe(sao2_oe),
		.i_pmod_out(pmod_out),
		.i_pmod_oe(pmod_oe),
		.i_irda_sd(irda_sd),
		.i_fsel_d(fsel_d),
		.i_fsel_c(fsel_c),
		.i_programn(programn)
	);

	function automatic bus_word_t misc_addr(input reg_index_t idx);
		return {`SOC_REGION_MISC, 21'h0, idx, 2'b00};
	endfunction

	function automatic bus_word_t ram_addr(input ram_index_t idx);
		return {`SOC_REGION_RAM, 20'h0, idx, 2'b00};
	endfunction

	task automatic start_test(input string name);
		i_checker.test_name = name;
	endtask

	// --------------------
	// bus master
	// --------------------
	task automatic bus_access(input bus_word_t addr, input bus_word_t wdata,
		input bus_strb_t wstrb);
		int cycles;
		cycles = 0;
		@(negedge clk48m);
		mem_valid = 1'b1;
		mem_addr = addr;
		mem_wdata = wdata;
		mem_wstrb = wstrb;
		@(posedge clk48m);
		while (!mem_ready && cycles < 20) begin
			cycles++;
			@(posedge clk48m);
		end
		if (!mem_ready) begin
			failure_count++;
			$display("no ready from the DUT within 20 cycles at address %h", addr);
		end
		// valid drops for at least one cycle
		@(negedge clk48m);
		mem_valid = 1'b0;
		mem_addr = '0;
		mem_wdata = '0;
		mem_wstrb = '0;
	endtask

	task automatic write_word(input bus_word_t addr, input bus_word_t data);
		bus_access(addr, data, 4'hF);
	endtask

	task automatic read_word(input bus_word_t addr);
		bus_access(addr, 32'h0, 4'h0);
	endtask

	task automatic drive_random_pins();
		rnd = $random(seed);
		btn = rnd[7:0];
		sao1_in = rnd[13:8];
		sao2_in = rnd[19:14];
		pmod_in = rnd[27:20];
		usb_vdet = rnd[31];
		rnd = $random(seed);
		genio_in = rnd[29:0];
	endtask

	// --------------------
	// tests
	// --------------------
	task automatic run_unmapped();
		start_test("unmapped");
		for (int r = 0; r < 16; r++) begin
			if (r != 2 && r != 4) begin
				rnd = $random(seed);
				write_word({r[3:0], rnd[27:0]}, $random(seed));
				read_word({r[3:0], rnd[27:0]});
			end
		end
	endtask

	task automatic run_genio();
		start_test("genio");
		repeat (8) begin
			drive_random_pins();
			write_word(misc_addr(`MISC_REG_GENIO_OUT), $random(seed));
			read_word(misc_addr(`MISC_REG_GENIO_OUT));
			write_word(misc_addr(`MISC_REG_GENIO_W2S), $random(seed));
			read_word(misc_addr(`MISC_REG_GENIO_OUT));
			write_word(misc_addr(`MISC_REG_GENIO_W2C), $random(seed));
			read_word(misc_addr(`MISC_REG_GENIO_OUT));
			write_word(misc_addr(`MISC_REG_GENIO_OE), $random(seed));
			read_word(misc_addr(`MISC_REG_GENIO_OE));
			read_word(misc_addr(`MISC_REG_GENIO_IN));
		end
	endtask

	task automatic run_gpext();
		start_test("gpext");
		repeat (8) begin
			drive_random_pins();
			write_word(misc_addr(`MISC_REG_GPEXT_OUT), $random(seed));
			read_word(misc_addr(`MISC_REG_GPEXT_OUT));
			write_word(misc_addr(`MISC_REG_GPEXT_W2S), $random(seed));
			read_word(misc_addr(`MISC_REG_GPEXT_OUT));
			write_word(misc_addr(`MISC_REG_GPEXT_W2C), $random(seed));
			read_word(misc_addr(`MISC_REG_GPEXT_OUT));
			write_word(misc_addr(`MISC_REG_GPEXT_OE), $random(seed));
			read_word(misc_addr(`MISC_REG_GPEXT_OE));
			read_word(misc_addr(`MISC_REG_GPEXT_IN));
			read_word(misc_addr(`MISC_REG_GPEXT_W2S));
		end
	endtask

	task automatic run_ram();
		ram_index_t idx;
		start_test("ram");
		// full words first so every byte is known
		for (int i = 0; i < `RAM_WORDS; i++) begin
			idx = i[5:0];
			write_word(ram_addr(idx), $random(seed));
		end
		repeat (40) begin
			rnd = $random(seed);
			idx = rnd[5:0];
			bus_access(ram_addr(idx), $random(seed), rnd[11:8]);
		end
		for (int i = 0; i < `RAM_WORDS; i++) begin
			idx = i[5:0];
			read_word(ram_addr(idx));
		end
	endtask

	task automatic run_basic_regs();
		start_test("basic regs");
		write_word(misc_addr(`MISC_REG_LED), $random(seed));
		read_word(misc_addr(`MISC_REG_LED));
		drive_random_pins();
		read_word(misc_addr(`MISC_REG_BTN));
		read_word(misc_addr(`MISC_REG_SOC_VER));
		write_word(misc_addr(`MISC_REG_SOC_VER), 32'h1);
		read_word(misc_addr(`MISC_REG_SOC_VER));
		// whole index space, dropped registers read 0
		for (int i = 0; i < 32; i++) begin
			read_word(misc_addr(i[4:0]));
		end
	endtask

	task automatic run_flash_select();
		int cycles;
		start_test("flash select");
		write_word(misc_addr(`MISC_REG_FLASH_SEL), 32'h0000_0001);
		repeat (12) @(negedge clk48m);
		read_word(misc_addr(`MISC_REG_FLASH_SEL));
		start_test("reload");
		write_word(misc_addr(`MISC_REG_FLASH_SEL), {`RELOAD_MAGIC, 8'h00});
		cycles = 0;
		while (programn && cycles < 10) begin
			@(posedge clk48m);
			cycles++;
		end
		if (programn) begin
			failure_count++;
			$display("programn did not go low within 10 cycles of the reload write");
		end
		repeat (10) @(negedge clk48m);
	endtask

	initial begin
		seed = 32'h9da0;
		failure_count = 0;
		rst = 1'b1;
		mem_valid = 1'b0;
		mem_addr = '0;
		mem_wdata = '0;
		mem_wstrb = '0;
		btn = '0;
		genio_in = '0;
		sao1_in = '0;
		sao2_in = '0;
		pmod_in = '0;
		usb_vdet = 1'b0;
		repeat (16) @(negedge clk48m);
		rst = 1'b0;
		repeat (2) @(negedge clk48m);

		run_unmapped();
		run_genio();
		run_gpext();
		run_ram();
		run_basic_regs();
		// programn stays low after this one
		run_flash_select();

		repeat (4) @(negedge clk48m);
		$display("checks %0d, errors %0d, other failures %0d",
			i_checker.check_count, i_checker.error_count, failure_count);
		if (i_checker.error_count == 0 && failure_count == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: verilog.f
+incdir+include
source/soc_pkg.sv
source/periph_bus_if.sv
source/bus_decoder.sv
source/misc_regs.sv
source/reload_sequencer.sv
source/scratch_ram.sv
source/soc_io_top.sv
verif/soc_io_checker.sv
verif/tb_soc_io.sv

// File: Bender.yml
package:
  name: soc_io

export_include_dirs:
  - include

sources:
  # rtl, in compile order
  - include_dirs:
      - include
    files:
      - source/soc_pkg.sv
      - source/periph_bus_if.sv
      - source/bus_decoder.sv
      - source/misc_regs.sv
      - source/reload_sequencer.sv
      - source/scratch_ram.sv
      - source/soc_io_top.sv

  # testbench
  - target: simulation
    include_dirs:
      - include
    files:
      - verif/soc_io_checker.sv
      - verif/tb_soc_io.sv
